// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rename_pkg.sv
      - rtl/rename_freelist.sv
      - rtl/rename_map_table.sv
      - rtl/rename_commit_map.sv
      - rtl/rename_bypass.sv
      - rtl/rename_unit.sv
  - target: simulation
    include_dirs:
      - rtl
      - sim
    files:
      - sim/tb_rename_unit.sv

// ==== rtl/rename_bypass.sv ====
// Dependency check inside one rename group.
// A source or destination that matches the destination of an earlier lane
// takes that lane's freshly allocated id instead of the map table value.
// Pure combinational; lane 0 passes through.

`timescale 1ns/1ns
`include "rename_macros.svh"

module rename_bypass
  import rename_pkg::*;
(
  input  front_grp_t i_front,
  input  rnid_t      i_new_rnid [`DISP_WIDTH],

  // values from the map table
  input  rnid_t      i_src_rnid [`DISP_WIDTH][`NUM_SRC],
  input  rnid_t      i_rd_old_rnid [`DISP_WIDTH],

  output rnid_t      o_src_rnid [`DISP_WIDTH][`NUM_SRC],
  output rnid_t      o_rd_old_rnid [`DISP_WIDTH]
);

  logic [`DISP_WIDTH-1:0] w_writes;  // lane renames a real destination

  always_comb begin
    for (int d = 0; d < `DISP_WIDTH; d++) begin
      w_writes[d] = i_front.inst[d].valid & i_front.inst[d].rd.valid &
                    (i_front.inst[d].rd.idx != '0);
    end
  end

  // --------------------------------------------------
  // override search
  // --------------------------------------------------
  always_comb begin
    for (int d = 0; d < `DISP_WIDTH; d++) begin
      for (int s = 0; s < `NUM_SRC; s++) begin
        o_src_rnid[d][s] = i_src_rnid[d][s];
      end
      o_rd_old_rnid[d] = i_rd_old_rnid[d];

      // earlier lanes in ascending order, so the nearest match lands last
      for (int p = 0; p < d; p++) begin
        if (w_writes[p]) begin
          for (int s = 0; s < `NUM_SRC; s++) begin
            if (i_front.inst[p].rd.idx == i_front.inst[d].src[s].idx) begin
              o_src_rnid[d][s] = i_new_rnid[p];
            end
          end
          if (i_front.inst[p].rd.idx == i_front.inst[d].rd.idx) begin
            o_rd_old_rnid[d] = i_new_rnid[p];  // old id is the in-group one
          end
        end
      end
    end
  end

endmodule

// ==== rtl/rename_commit_map.sv ====
// Committed (architectural) map from register to physical id.
// Written by live committing slots; read whole when a flush restores
// the speculative map.

`timescale 1ns/1ns
`include "rename_macros.svh"

module rename_commit_map
  import rename_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,

  input  commit_grp_t i_commit,

  output rnid_t       o_map [`ARCH_REGS]
);

  rnid_t r_map [`ARCH_REGS];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < `ARCH_REGS; r++) begin
        r_map[r] <= rnid_t'(r);
      end
    end else if (i_commit.commit) begin
      for (int d = 0; d < `DISP_WIDTH; d++) begin
        // dead slots never reached architectural state
        if (i_commit.slot[d].valid && !i_commit.slot[d].dead &&
            i_commit.slot[d].rd_valid && i_commit.slot[d].rd_idx != '0) begin
          r_map[i_commit.slot[d].rd_idx] <= i_commit.slot[d].rd_rnid;
        end
      end
    end
  end

  assign o_map = r_map;

endmodule

// ==== rtl/rename_freelist.sv ====
// Free list of physical register ids for one dispatch lane.
// Circular FIFO that starts full with INIT_BASE and the ids after it.
// The head id is shown combinationally; pop and push may share a cycle.

`timescale 1ns/1ns
`include "rename_macros.svh"

module rename_freelist
  import rename_pkg::*;
#(
  parameter int INIT_BASE = 32
) (
  input  logic  i_clk,
  input  logic  i_reset_n,

  input  logic  i_push,
  input  rnid_t i_push_id,

  input  logic  i_pop,
  output rnid_t o_pop_id,

  output logic  o_empty
);

  localparam int PTR_W = $clog2(`FLIST_DEPTH);

  rnid_t            r_entry [`FLIST_DEPTH];
  logic [PTR_W-1:0] r_head;
  logic [PTR_W-1:0] r_tail;
  logic [PTR_W:0]   r_count;  // one extra bit to hold a full count
  logic             w_pop;

  assign o_empty  = (r_count == '0);
  assign o_pop_id = r_entry[r_head];
  assign w_pop    = i_pop & ~o_empty;  // never step past an empty head

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;  // full, so tail wraps onto head
      r_count <= (PTR_W+1)'(`FLIST_DEPTH);
    end else begin
      if (w_pop) begin
        r_head <= r_head + 1'b1;
      end
      if (i_push) begin
        r_tail <= r_tail + 1'b1;
      end
      case ({i_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // both or neither
      endcase
    end
  end

  // --------------------------------------------------
  // id storage
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `FLIST_DEPTH; i++) begin
        r_entry[i] <= rnid_t'(INIT_BASE + i);
      end
    end else if (i_push) begin
      r_entry[r_tail] <= i_push_id;
    end
  end

endmodule

// ==== rtl/rename_macros.svh ====
// Size parameters of the integer rename stage.
// Included by the package and by every module that sizes ports or loops.

`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// --------------------------------------------------
// group shape
// --------------------------------------------------
`define DISP_WIDTH 2   // instructions renamed per cycle
`define NUM_SRC 2      // source operands per instruction

// --------------------------------------------------
// architectural side
// --------------------------------------------------
`define ARCH_REGS 32
`define ARCH_IDX_W 5

// --------------------------------------------------
// physical side
// --------------------------------------------------
`define FLIST_DEPTH 16  // ids held by each lane free list
`define RNID_COUNT 64   // arch regs plus all free list entries
`define RNID_W 6

`endif

// ==== rtl/rename_map_table.sv ====
// Speculative map from architectural register to physical id.
// Read combinationally for every source and old destination of the group.
// Written by the renamed destinations at fire, or loaded whole on restore.

`timescale 1ns/1ns
`include "rename_macros.svh"

module rename_map_table
  import rename_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  // source lookups
  input  arch_idx_t              i_src_idx [`DISP_WIDTH][`NUM_SRC],
  output rnid_t                  o_src_rnid [`DISP_WIDTH][`NUM_SRC],

  // destination lookup, also the update address
  input  arch_idx_t              i_rd_idx [`DISP_WIDTH],
  output rnid_t                  o_rd_old_rnid [`DISP_WIDTH],

  input  logic [`DISP_WIDTH-1:0] i_update,
  input  rnid_t                  i_update_rnid [`DISP_WIDTH],

  input  logic                   i_restore,
  input  rnid_t                  i_restore_map [`ARCH_REGS]
);

  rnid_t r_map [`ARCH_REGS];

  // --------------------------------------------------
  // read ports
  // --------------------------------------------------
  always_comb begin
    for (int d = 0; d < `DISP_WIDTH; d++) begin
      for (int s = 0; s < `NUM_SRC; s++) begin
        o_src_rnid[d][s] = r_map[i_src_idx[d][s]];
      end
      o_rd_old_rnid[d] = r_map[i_rd_idx[d]];  // pre-group value
    end
  end

  // --------------------------------------------------
  // update and restore
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < `ARCH_REGS; r++) begin
        r_map[r] <= rnid_t'(r);  // identity map
      end
    end else if (i_restore) begin
      // restore takes priority over a rename in the same cycle
      for (int r = 0; r < `ARCH_REGS; r++) begin
        r_map[r] <= i_restore_map[r];
      end
    end else begin
      // ascending order, last lane to write an index wins
      for (int d = 0; d < `DISP_WIDTH; d++) begin
        if (i_update[d]) begin
          r_map[i_rd_idx[d]] <= i_update_rnid[d];
        end
      end
    end
  end

endmodule

// ==== rtl/rename_pkg.sv ====
// Packed struct types of the rename stage.
// Shared by the RTL and the testbench; sizes come from the macro header.

`include "rename_macros.svh"

package rename_pkg;

  typedef logic [`ARCH_IDX_W-1:0] arch_idx_t;
  typedef logic [`RNID_W-1:0]     rnid_t;

  // --------------------------------------------------
  // front end side
  // --------------------------------------------------
  typedef struct packed {
    logic      valid;
    arch_idx_t idx;
  } reg_ref_t;

  typedef struct packed {
    logic                      valid;
    reg_ref_t                  rd;
    reg_ref_t [`NUM_SRC-1:0]   src;
  } front_inst_t;

  typedef struct packed {
    front_inst_t [`DISP_WIDTH-1:0] inst;
  } front_grp_t;

  // --------------------------------------------------
  // dispatch side
  // --------------------------------------------------
  typedef struct packed {
    logic                  valid;
    logic                  rd_valid;
    rnid_t                 rd_rnid;
    rnid_t                 rd_old_rnid;
    rnid_t [`NUM_SRC-1:0]  src_rnid;
  } disp_inst_t;

  typedef struct packed {
    disp_inst_t [`DISP_WIDTH-1:0] inst;
  } disp_grp_t;

  // --------------------------------------------------
  // commit side
  // --------------------------------------------------
  typedef struct packed {
    logic      valid;
    logic      dead;      // squashed, its new id goes back
    logic      rd_valid;
    arch_idx_t rd_idx;
    rnid_t     rd_rnid;
    rnid_t     old_rnid;
  } commit_slot_t;

  typedef struct packed {
    logic                          commit;
    logic                          flush;  // restore spec map from committed map
    commit_slot_t [`DISP_WIDTH-1:0] slot;
  } commit_grp_t;

endpackage

// ==== rtl/rename_unit.sv ====
// Integer register rename stage, top level.
// Renames one group per fire (valid and ready) with zero latency; commit
// results return ids to the per-lane free lists one cycle after the
// committed map is written, and a flush restores the speculative map.

`timescale 1ns/1ns
`include "rename_macros.svh"

module rename_unit
  import rename_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,

  input  logic        i_front_valid,
  input  front_grp_t  i_front,
  output logic        o_front_ready,

  output disp_grp_t   o_disp,

  input  commit_grp_t i_commit
);

  logic                   w_fire;
  logic [`DISP_WIDTH-1:0] w_empty;
  logic [`DISP_WIDTH-1:0] w_rd_req;    // lane needs a new id
  logic [`DISP_WIDTH-1:0] w_pop;
  logic [`DISP_WIDTH-1:0] w_push;
  rnid_t                  w_head_id [`DISP_WIDTH];
  rnid_t                  w_new_rnid [`DISP_WIDTH];
  rnid_t                  w_push_id [`DISP_WIDTH];

  arch_idx_t              w_src_idx [`DISP_WIDTH][`NUM_SRC];
  arch_idx_t              w_rd_idx [`DISP_WIDTH];
  rnid_t                  w_tbl_src_rnid [`DISP_WIDTH][`NUM_SRC];
  rnid_t                  w_tbl_old_rnid [`DISP_WIDTH];
  rnid_t                  w_src_rnid [`DISP_WIDTH][`NUM_SRC];
  rnid_t                  w_old_rnid [`DISP_WIDTH];

  commit_grp_t            r_commit;    // commit group, one cycle late
  logic                   w_restore;
  rnid_t                  w_commit_map [`ARCH_REGS];

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------
  assign o_front_ready = ~|w_empty;  // every lane must have an id ready
  assign w_fire        = i_front_valid & o_front_ready;

  // --------------------------------------------------
  // per lane free lists
  // --------------------------------------------------
  for (genvar d = 0; d < `DISP_WIDTH; d++) begin : g_lane
    assign w_rd_req[d] = i_front.inst[d].valid & i_front.inst[d].rd.valid &
                         (i_front.inst[d].rd.idx != '0);
    assign w_pop[d]      = w_fire & w_rd_req[d];
    assign w_new_rnid[d] = w_rd_req[d] ? w_head_id[d] : '0;  // x0 stays 0

    // live slot frees the old id, dead slot frees its own new id
    assign w_push[d] = r_commit.commit & r_commit.slot[d].valid &
                       r_commit.slot[d].rd_valid & (r_commit.slot[d].rd_idx != '0);
    assign w_push_id[d] = r_commit.slot[d].dead ? r_commit.slot[d].rd_rnid :
                                                  r_commit.slot[d].old_rnid;

    rename_freelist #(
      .INIT_BASE (`RNID_COUNT - `DISP_WIDTH * `FLIST_DEPTH + `FLIST_DEPTH * d)
    ) u_freelist (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_push    (w_push[d]),
      .i_push_id (w_push_id[d]),
      .i_pop     (w_pop[d]),
      .o_pop_id  (w_head_id[d]),
      .o_empty   (w_empty[d])
    );

    assign w_rd_idx[d] = i_front.inst[d].rd.idx;
    for (genvar s = 0; s < `NUM_SRC; s++) begin : g_src
      assign w_src_idx[d][s] = i_front.inst[d].src[s].idx;
    end
  end

  // --------------------------------------------------
  // commit delay and restore
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_commit <= '0;
    end else begin
      r_commit <= i_commit;
    end
  end

  // committed map already holds the flushing group's writes here
  assign w_restore = r_commit.commit & r_commit.flush;

  rename_commit_map u_commit_map (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_commit  (i_commit),
    .o_map     (w_commit_map)
  );

  rename_map_table u_map_table (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_src_idx     (w_src_idx),
    .o_src_rnid    (w_tbl_src_rnid),
    .i_rd_idx      (w_rd_idx),
    .o_rd_old_rnid (w_tbl_old_rnid),
    .i_update      (w_pop),
    .i_update_rnid (w_new_rnid),
    .i_restore     (w_restore),
    .i_restore_map (w_commit_map)
  );

  rename_bypass u_bypass (
    .i_front       (i_front),
    .i_new_rnid    (w_new_rnid),
    .i_src_rnid    (w_tbl_src_rnid),
    .i_rd_old_rnid (w_tbl_old_rnid),
    .o_src_rnid    (w_src_rnid),
    .o_rd_old_rnid (w_old_rnid)
  );

  // --------------------------------------------------
  // dispatch output
  // --------------------------------------------------
  always_comb begin
    for (int d = 0; d < `DISP_WIDTH; d++) begin
      o_disp.inst[d].valid       = w_fire & i_front.inst[d].valid;
      o_disp.inst[d].rd_valid    = w_fire & i_front.inst[d].valid &
                                   i_front.inst[d].rd.valid;
      o_disp.inst[d].rd_rnid     = w_new_rnid[d];
      o_disp.inst[d].rd_old_rnid = w_old_rnid[d];
      for (int s = 0; s < `NUM_SRC; s++) begin
        o_disp.inst[d].src_rnid[s] = w_src_rnid[d][s];
      end
    end
  end

endmodule

// ==== sim/tb_rename_model.svh ====
// Reference model of the rename stage, included inside the testbench module.
// Keeps the speculative and committed maps, the per-lane free queues, the
// set of ids in use and the LFSR behind the random operands.

`ifndef TB_RENAME_MODEL_SVH
`define TB_RENAME_MODEL_SVH

rnid_t                  spec_map [`ARCH_REGS];
rnid_t                  arch_map [`ARCH_REGS];
rnid_t                  free_q [`DISP_WIDTH][$];
logic [`RNID_COUNT-1:0] busy;    // ids outside every free list
logic [`RNID_COUNT-1:0] wanted;  // freed by a dead slot and not yet seen at the ports
logic [31:0]            lfsr_state = 32'h3429;

// fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

task automatic reset_model();
  busy   = '0;
  wanted = '0;
  for (int r = 0; r < `ARCH_REGS; r++) begin
    spec_map[r] = rnid_t'(r);  // identity
    arch_map[r] = rnid_t'(r);
    busy[r]     = 1'b1;
  end
  for (int d = 0; d < `DISP_WIDTH; d++) begin
    for (int i = 0; i < `FLIST_DEPTH; i++) begin
      free_q[d].push_back(rnid_t'(`ARCH_REGS + `FLIST_DEPTH * d + i));
    end
  end
endtask

// lanes in program order, so a later lane reads what an earlier one wrote
task automatic rename_expect(input front_grp_t g, output disp_grp_t e);
  e = '0;
  for (int d = 0; d < `DISP_WIDTH; d++) begin
    e.inst[d].valid       = g.inst[d].valid;
    e.inst[d].rd_valid    = g.inst[d].valid & g.inst[d].rd.valid;
    e.inst[d].rd_old_rnid = spec_map[g.inst[d].rd.idx];
    for (int s = 0; s < `NUM_SRC; s++) begin
      e.inst[d].src_rnid[s] = spec_map[g.inst[d].src[s].idx];
    end
    if (e.inst[d].rd_valid && g.inst[d].rd.idx != '0) begin
      e.inst[d].rd_rnid          = free_q[d].pop_front();
      spec_map[g.inst[d].rd.idx] = e.inst[d].rd_rnid;
      busy[e.inst[d].rd_rnid]    = 1'b1;
    end
  end
endtask

// full effect of one commit group as seen after its second edge
task automatic apply_commit(input commit_grp_t c);
  commit_slot_t s;
  rnid_t        id;
  for (int d = 0; d < `DISP_WIDTH; d++) begin
    s  = c.slot[d];
    id = s.dead ? s.rd_rnid : s.old_rnid;
    if (c.commit && s.valid && s.rd_valid && s.rd_idx != '0) begin
      if (!s.dead) begin
        arch_map[s.rd_idx] = s.rd_rnid;
      end
      free_q[d].push_back(id);
      busy[id]   = 1'b0;
      wanted[id] = s.dead;
    end
  end
  if (c.commit && c.flush) begin
    spec_map = arch_map;
  end
endtask

`endif

// ==== sim/tb_rename_unit.sv ====
// Testbench for the rename stage top level.
// Drives rename groups and commit groups on the falling edge, checks every
// fired group against the reference model and prints a result line.

`timescale 1ns/1ns
`include "rename_macros.svh"

module tb_rename_unit
  import rename_pkg::*;
;

  localparam int TEST_CYCLES     = 1200;  // rough length of all tests
  localparam int WATCHDOG_CYCLES = TEST_CYCLES * 5 / 2;
  localparam int STALL_LIMIT     = 20;

  logic        clk;
  logic        reset_n;
  logic        front_valid;
  front_grp_t  front;
  logic        front_ready;
  disp_grp_t   disp;
  commit_grp_t commit;

  int          errors = 0;
  int          checks = 0;
  string       test_name = "reset_state";
  commit_grp_t pend_commit [$];  // renamed and not yet retired

  `include "tb_rename_model.svh"

  rename_unit rename_unit_inst (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_front_valid (front_valid),
    .i_front       (front),
    .o_front_ready (front_ready),
    .o_disp        (disp),
    .i_commit      (commit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  // --------------------------------------------------
  // port checks on every edge
  // --------------------------------------------------
  quiet_without_fire: assert property (@(posedge clk) disable iff (!reset_n)
    !(front_valid && front_ready) |-> !(disp.inst[0].valid || disp.inst[1].valid))
    else begin
      errors++;
      $display("FAILED %s expected valid 00 actual %b%b", test_name,
               $sampled(disp.inst[1].valid), $sampled(disp.inst[0].valid));
    end

  lanes_get_distinct_ids: assert property (@(posedge clk) disable iff (!reset_n)
    (front_valid && front_ready && disp.inst[0].rd_rnid != '0) |->
      disp.inst[0].rd_rnid != disp.inst[1].rd_rnid)
    else begin
      errors++;
      $display("%s: both lanes were given id %0d in one group", test_name,
               $sampled(disp.inst[0].rd_rnid));
    end

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  function automatic front_inst_t make_inst(input logic rd_valid, input int rd,
                                            input int src0, input int src1);
    front_inst_t f;
    f.valid        = 1'b1;
    f.rd.valid     = rd_valid;
    f.rd.idx       = arch_idx_t'(rd);
    f.src[0].valid = 1'b1;
    f.src[0].idx   = arch_idx_t'(src0);
    f.src[1].valid = 1'b1;
    f.src[1].idx   = arch_idx_t'(src1);
    return f;
  endfunction

  function automatic front_grp_t random_group();
    front_grp_t g;
    for (int d = 0; d < `DISP_WIDTH; d++) begin
      g.inst[d].valid    = (rand_bits(2) != 0);  // mostly valid
      g.inst[d].rd.valid = (rand_bits(2) != 0);
      g.inst[d].rd.idx   = arch_idx_t'(rand_bits(`ARCH_IDX_W));
      for (int s = 0; s < `NUM_SRC; s++) begin
        g.inst[d].src[s].valid = (rand_bits(1) != 0);
        g.inst[d].src[s].idx   = arch_idx_t'(rand_bits(`ARCH_IDX_W));
      end
    end
    return g;
  endfunction

  // present one group, wait for ready, check it in the fire cycle
  task automatic send_group(input front_grp_t g);
    disp_grp_t   exp;
    commit_grp_t c;
    int          waits;
    waits = 0;
    @(negedge clk);
    front_valid = 1'b1;
    front       = g;
    #1;
    while (!front_ready && waits < STALL_LIMIT) begin
      @(negedge clk);
      #1;
      waits++;
    end
    if (!front_ready) begin
      errors++;
      $display("%s: ready stayed low, the group was never accepted", test_name);
    end else begin
      for (int d = 0; d < `DISP_WIDTH; d++) begin
        assert (!disp.inst[d].rd_valid || disp.inst[d].rd_rnid == '0 ||
                !busy[disp.inst[d].rd_rnid])
          else begin
            errors++;
            $display("%s: id %0d handed out while still in use", test_name,
                     disp.inst[d].rd_rnid);
          end
        if (disp.inst[d].rd_valid && disp.inst[d].rd_rnid != '0) begin
          wanted[disp.inst[d].rd_rnid] = 1'b0;  // squashed id seen again
        end
      end
      rename_expect(g, exp);
      checks++;
      assert (disp === exp) else begin
        errors++;
        $display("FAILED %s expected %h actual %h", test_name, exp, disp);
      end
      c        = '0;
      c.commit = 1'b1;
      for (int d = 0; d < `DISP_WIDTH; d++) begin
        c.slot[d].valid    = exp.inst[d].rd_valid;
        c.slot[d].rd_valid = exp.inst[d].rd_valid;
        c.slot[d].rd_idx   = g.inst[d].rd.idx;
        c.slot[d].rd_rnid  = exp.inst[d].rd_rnid;
        c.slot[d].old_rnid = exp.inst[d].rd_old_rnid;
      end
      pend_commit.push_back(c);
    end
    @(negedge clk);  // fire edge has passed
    front_valid = 1'b0;
  endtask

  task automatic retire_oldest(input logic dead);
    commit_grp_t c;
    c       = pend_commit.pop_front();
    c.flush = dead;  // squashed groups also restore the map
    for (int d = 0; d < `DISP_WIDTH; d++) begin
      c.slot[d].dead = dead;
    end
    @(negedge clk);
    commit = c;
    @(negedge clk);
    commit = '0;
    @(posedge clk);  // ids pushed and map restored at edge 2
    apply_commit(c);
  endtask

  task automatic keep_supplied();
    while ((free_q[0].size() == 0 || free_q[1].size() == 0) && pend_commit.size() > 0) begin
      retire_oldest(1'b0);
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    front_grp_t g;
    reset_n     = 1'b0;
    front_valid = 1'b0;
    front       = '0;
    commit      = '0;
    reset_model();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    #1;
    assert (front_ready) else begin
      errors++;
      $display("%s: ready low after reset", test_name);
    end
    g.inst[0] = make_inst(1'b0, 0, 1, 2);  // identity map reads
    g.inst[1] = make_inst(1'b0, 0, 2, 1);
    send_group(g);

    test_name = "allocation_order";
    g.inst[0] = make_inst(1'b1, 3, 1, 2);
    g.inst[1] = make_inst(1'b1, 4, 2, 0);
    send_group(g);
    g.inst[0] = make_inst(1'b1, 0, 3, 4);  // x0 takes nothing
    g.inst[1] = make_inst(1'b0, 4, 4, 3);
    send_group(g);
    repeat (4) send_group(random_group());

    test_name = "intra_group_bypass";
    g.inst[0] = make_inst(1'b1, 7, 1, 2);
    g.inst[1] = make_inst(1'b1, 7, 7, 3);
    send_group(g);
    g.inst[0] = make_inst(1'b1, 9, 7, 7);
    g.inst[1] = make_inst(1'b1, 10, 9, 9);
    send_group(g);

    test_name = "freelist_exhaustion";
    while (free_q[0].size() > 0) begin
      g.inst[0] = make_inst(1'b1, int'(rand_bits(5) % 31) + 1, 5, 6);
      g.inst[1] = make_inst(1'b0, 0, 7, 8);
      send_group(g);
    end
    @(negedge clk);
    front_valid = 1'b1;  // this group has to wait
    front       = g;
    repeat (3) begin
      #1;
      assert (!front_ready) else begin
        errors++;
        $display("%s: ready high with the lane 0 free list empty", test_name);
      end
      @(negedge clk);
    end
    front_valid = 1'b0;

    test_name = "freelist_return";
    while (free_q[0].size() == 0 && pend_commit.size() > 0) begin
      retire_oldest(1'b0);
    end
    #1;
    assert (front_ready) else begin
      errors++;
      $display("%s: ready still low after ids were returned", test_name);
    end
    repeat (10) begin
      keep_supplied();
      send_group(random_group());
    end

    test_name = "flush_restore";
    keep_supplied();
    g.inst[0] = make_inst(1'b1, 5, 5, 6);
    g.inst[1] = make_inst(1'b1, 6, 5, 1);
    send_group(g);
    while (pend_commit.size() > 2) begin
      retire_oldest(1'b0);
    end
    while (pend_commit.size() > 0) begin
      retire_oldest(1'b1);
    end
    g.inst[0] = make_inst(1'b0, 0, 5, 6);  // must read the committed map
    g.inst[1] = make_inst(1'b0, 0, 7, 9);
    send_group(g);
    for (int n = 0; n < 150 && (n < 20 || wanted != '0); n++) begin
      keep_supplied();
      send_group(random_group());
    end
    assert (wanted == '0) else begin
      errors++;
      $display("%s: squashed ids never came back from their free lists", test_name);
    end

    repeat (2) @(negedge clk);
    $display("groups checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
+incdir+sim
rtl/rename_pkg.sv
rtl/rename_freelist.sv
rtl/rename_map_table.sv
rtl/rename_commit_map.sv
rtl/rename_bypass.sv
rtl/rename_unit.sv
sim/tb_rename_unit.sv
